//--- design/apb_pkg.sv
package apb_pkg;

  // Default bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // Address bit that splits the APB space between the two slaves
  localparam int SLAVE_SEL_BIT = 11;  // 0 selects the RAM, 1 the register block

  // Register indices within the register block, taken from address bits 3:2
  localparam logic [1:0] REG_SCRATCH0 = 2'd0;
  localparam logic [1:0] REG_SCRATCH1 = 2'd1;
  localparam logic [1:0] REG_ID       = 2'd2;  // Read only
  localparam logic [1:0] REG_WCOUNT   = 2'd3;  // Counts completed writes

  // Identification word returned by REG_ID
  localparam logic [31:0] REG_ID_VALUE = 32'hA9B0_0C01;

endpackage

//--- design/iob2apb.sv
`timescale 1ns/1ps

module iob2apb #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32
) (
  input  logic                clk_i,
  input  logic                rst_i,

  // IOb request port
  input  logic                iob_avalid_i,
  input  logic [ADDR_W-1:0]   iob_addr_i,
  input  logic [DATA_W-1:0]   iob_wdata_i,
  input  logic [DATA_W/8-1:0] iob_wstrb_i,
  output logic                iob_ready_o,
  output logic                iob_rvalid_o,
  output logic [DATA_W-1:0]   iob_rdata_o,

  // APB master port
  output logic                apb_sel_o,
  output logic                apb_enable_o,
  output logic [ADDR_W-1:0]   apb_addr_o,
  output logic                apb_write_o,
  output logic [DATA_W/8-1:0] apb_wstrb_o,
  output logic [DATA_W-1:0]   apb_wdata_o,
  input  logic                apb_ready_i,
  input  logic [DATA_W-1:0]   apb_rdata_i
);

  localparam logic ST_IDLE = 1'b0;
  localparam logic ST_XFER = 1'b1;  // Setup and access phases

  logic                state, state_nxt;
  logic                sel_nxt, enable_nxt, write_nxt;
  logic [ADDR_W-1:0]   addr_nxt;
  logic [DATA_W/8-1:0] wstrb_nxt;
  logic [DATA_W-1:0]   wdata_nxt;
  logic                ready_nxt, rvalid_nxt;
  logic [DATA_W-1:0]   rdata_nxt;

  always_comb begin
    state_nxt  = state;
    sel_nxt    = apb_sel_o;
    enable_nxt = apb_enable_o;
    addr_nxt   = apb_addr_o;
    write_nxt  = apb_write_o;
    wstrb_nxt  = apb_wstrb_o;
    wdata_nxt  = apb_wdata_o;
    ready_nxt  = iob_ready_o;
    rvalid_nxt = 1'b0;           // Single-cycle pulse
    rdata_nxt  = iob_rdata_o;    // Holds after the pulse

    case (state)
      ST_IDLE: begin
        if (iob_avalid_i) begin  // ready is high in idle, so this is acceptance
          addr_nxt  = iob_addr_i;
          write_nxt = |iob_wstrb_i;
          wstrb_nxt = iob_wstrb_i;
          wdata_nxt = iob_wdata_i;
          sel_nxt   = 1'b1;      // Setup phase
          ready_nxt = 1'b0;
          state_nxt = ST_XFER;
        end
      end
      default: begin
        enable_nxt = 1'b1;       // Access phase from the next cycle
        // Slave ready can only be high once enable is already set
        if (apb_ready_i) begin
          rdata_nxt  = apb_rdata_i;
          rvalid_nxt = 1'b1;
          ready_nxt  = 1'b1;
          sel_nxt    = 1'b0;
          enable_nxt = 1'b0;
          state_nxt  = ST_IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state        <= ST_IDLE;
      apb_sel_o    <= 1'b0;
      apb_enable_o <= 1'b0;
      apb_addr_o   <= '0;
      apb_write_o  <= 1'b0;
      apb_wstrb_o  <= '0;
      apb_wdata_o  <= '0;
      iob_ready_o  <= 1'b1;
      iob_rvalid_o <= 1'b0;
      iob_rdata_o  <= '0;
    end else begin
      state        <= state_nxt;
      apb_sel_o    <= sel_nxt;
      apb_enable_o <= enable_nxt;
      apb_addr_o   <= addr_nxt;
      apb_write_o  <= write_nxt;
      apb_wstrb_o  <= wstrb_nxt;
      apb_wdata_o  <= wdata_nxt;
      iob_ready_o  <= ready_nxt;
      iob_rvalid_o <= rvalid_nxt;
      iob_rdata_o  <= rdata_nxt;
    end
  end

endmodule

//--- design/apb_decoder.sv
`timescale 1ns/1ps

module apb_decoder #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32
) (
  // From and to the bridge
  input  logic              apb_sel_i,
  input  logic [ADDR_W-1:0] apb_addr_i,
  output logic              apb_ready_o,
  output logic [DATA_W-1:0] apb_rdata_o,

  // RAM slave
  output logic              ram_sel_o,
  input  logic              ram_ready_i,
  input  logic [DATA_W-1:0] ram_rdata_i,

  // Register block slave
  output logic              regs_sel_o,
  input  logic              regs_ready_i,
  input  logic [DATA_W-1:0] regs_rdata_i
);

  logic hit_regs;

  // A single address bit picks the slave, the rest alias inside each one
  assign hit_regs = apb_addr_i[apb_pkg::SLAVE_SEL_BIT];

  assign ram_sel_o  = apb_sel_i & ~hit_regs;
  assign regs_sel_o = apb_sel_i & hit_regs;

  // Return path follows the same bit
  always_comb begin
    if (hit_regs) begin
      apb_ready_o = regs_ready_i;
      apb_rdata_o = regs_rdata_i;
    end else begin
      apb_ready_o = ram_ready_i;
      apb_rdata_o = ram_rdata_i;
    end
  end

endmodule

//--- design/apb_ram.sv
`timescale 1ns/1ps

module apb_ram #(
  parameter int ADDR_W     = 32,
  parameter int DATA_W     = 32,
  parameter int RAM_ADDR_W = 8,   // Word address width
  parameter int RAM_WAIT   = 2    // Wait states per access
) (
  input  logic                clk_i,
  input  logic                rst_i,

  input  logic                apb_sel_i,
  input  logic                apb_enable_i,
  input  logic [ADDR_W-1:0]   apb_addr_i,
  input  logic                apb_write_i,
  input  logic [DATA_W/8-1:0] apb_wstrb_i,
  input  logic [DATA_W-1:0]   apb_wdata_i,
  output logic                apb_ready_o,
  output logic [DATA_W-1:0]   apb_rdata_o
);

  localparam int OFF_W  = $clog2(DATA_W/8);  // Byte offset bits
  localparam int WAIT_W = (RAM_WAIT > 0) ? $clog2(RAM_WAIT + 1) : 1;

  logic [DATA_W-1:0]     mem [2**RAM_ADDR_W];
  logic [RAM_ADDR_W-1:0] word_idx;
  logic [WAIT_W-1:0]     wait_cnt;
  logic                  access;

  assign word_idx = apb_addr_i[OFF_W +: RAM_ADDR_W];
  assign access   = apb_sel_i & apb_enable_i;

  // Ready once the access phase has lasted RAM_WAIT cycles
  assign apb_ready_o = access & (wait_cnt == WAIT_W'(RAM_WAIT));

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wait_cnt <= '0;
    end else if (access && !apb_ready_o) begin
      wait_cnt <= wait_cnt + 1'b1;
    end else begin
      wait_cnt <= '0;  // Done or idle, start over
    end
  end

  // Byte-strobed write on the ready cycle
  always_ff @(posedge clk_i) begin
    if (apb_ready_o && apb_write_i) begin
      for (int b = 0; b < DATA_W/8; b++) begin
        if (apb_wstrb_i[b]) mem[word_idx][8*b +: 8] <= apb_wdata_i[8*b +: 8];
      end
    end
  end

  assign apb_rdata_o = mem[word_idx];  // Sampled by the bridge only with ready

endmodule

//--- design/apb_regs.sv
`timescale 1ns/1ps

module apb_regs #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32
) (
  input  logic                clk_i,
  input  logic                rst_i,

  input  logic                apb_sel_i,
  input  logic                apb_enable_i,
  input  logic [ADDR_W-1:0]   apb_addr_i,
  input  logic                apb_write_i,
  input  logic [DATA_W/8-1:0] apb_wstrb_i,
  input  logic [DATA_W-1:0]   apb_wdata_i,
  output logic                apb_ready_o,
  output logic [DATA_W-1:0]   apb_rdata_o
);

  logic [DATA_W-1:0] scratch0, scratch1;
  logic [DATA_W-1:0] wcount;
  logic [1:0]        reg_idx;
  logic              wr_done;

  assign reg_idx     = apb_addr_i[3:2];
  assign apb_ready_o = apb_sel_i & apb_enable_i;  // No wait states
  assign wr_done     = apb_ready_o & apb_write_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      scratch0 <= '0;
      scratch1 <= '0;
      wcount   <= '0;
    end else if (wr_done) begin
      wcount <= wcount + 1'b1;  // Any index counts, wraps naturally
      for (int b = 0; b < DATA_W/8; b++) begin
        if (apb_wstrb_i[b]) begin
          if (reg_idx == apb_pkg::REG_SCRATCH0) scratch0[8*b +: 8] <= apb_wdata_i[8*b +: 8];
          if (reg_idx == apb_pkg::REG_SCRATCH1) scratch1[8*b +: 8] <= apb_wdata_i[8*b +: 8];
        end
      end
    end
  end

  // Read mux
  always_comb begin
    case (reg_idx)
      apb_pkg::REG_SCRATCH0: apb_rdata_o = scratch0;
      apb_pkg::REG_SCRATCH1: apb_rdata_o = scratch1;
      apb_pkg::REG_ID:       apb_rdata_o = DATA_W'(apb_pkg::REG_ID_VALUE);
      default:               apb_rdata_o = wcount;
    endcase
  end

endmodule

//--- design/apb_subsys_top.sv
`timescale 1ns/1ps

module apb_subsys_top #(
  parameter int ADDR_W     = apb_pkg::ADDR_W,
  parameter int DATA_W     = apb_pkg::DATA_W,
  parameter int RAM_ADDR_W = 8,
  parameter int RAM_WAIT   = 2
) (
  input  logic                clk_i,
  input  logic                rst_i,

  // IOb port
  input  logic                iob_avalid_i,
  input  logic [ADDR_W-1:0]   iob_addr_i,
  input  logic [DATA_W-1:0]   iob_wdata_i,
  input  logic [DATA_W/8-1:0] iob_wstrb_i,
  output logic                iob_ready_o,
  output logic                iob_rvalid_o,
  output logic [DATA_W-1:0]   iob_rdata_o
);

  // Bridge side of the APB bus
  logic                apb_sel, apb_enable, apb_write;
  logic [ADDR_W-1:0]   apb_addr;
  logic [DATA_W/8-1:0] apb_wstrb;
  logic [DATA_W-1:0]   apb_wdata;
  logic                apb_ready;
  logic [DATA_W-1:0]   apb_rdata;

  // Per-slave select and response
  logic                ram_sel, ram_ready;
  logic [DATA_W-1:0]   ram_rdata;
  logic                regs_sel, regs_ready;
  logic [DATA_W-1:0]   regs_rdata;

  iob2apb #(
    .ADDR_W (ADDR_W),
    .DATA_W (DATA_W)
  ) iob2apb_inst (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .iob_avalid_i (iob_avalid_i),
    .iob_addr_i   (iob_addr_i),
    .iob_wdata_i  (iob_wdata_i),
    .iob_wstrb_i  (iob_wstrb_i),
    .iob_ready_o  (iob_ready_o),
    .iob_rvalid_o (iob_rvalid_o),
    .iob_rdata_o  (iob_rdata_o),
    .apb_sel_o    (apb_sel),
    .apb_enable_o (apb_enable),
    .apb_addr_o   (apb_addr),
    .apb_write_o  (apb_write),
    .apb_wstrb_o  (apb_wstrb),
    .apb_wdata_o  (apb_wdata),
    .apb_ready_i  (apb_ready),
    .apb_rdata_i  (apb_rdata)
  );

  apb_decoder #(
    .ADDR_W (ADDR_W),
    .DATA_W (DATA_W)
  ) apb_decoder_inst (
    .apb_sel_i    (apb_sel),
    .apb_addr_i   (apb_addr),
    .apb_ready_o  (apb_ready),
    .apb_rdata_o  (apb_rdata),
    .ram_sel_o    (ram_sel),
    .ram_ready_i  (ram_ready),
    .ram_rdata_i  (ram_rdata),
    .regs_sel_o   (regs_sel),
    .regs_ready_i (regs_ready),
    .regs_rdata_i (regs_rdata)
  );

  // Enable, address and write data are shared by both slaves
  apb_ram #(
    .ADDR_W     (ADDR_W),
    .DATA_W     (DATA_W),
    .RAM_ADDR_W (RAM_ADDR_W),
    .RAM_WAIT   (RAM_WAIT)
  ) apb_ram_inst (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .apb_sel_i    (ram_sel),
    .apb_enable_i (apb_enable),
    .apb_addr_i   (apb_addr),
    .apb_write_i  (apb_write),
    .apb_wstrb_i  (apb_wstrb),
    .apb_wdata_i  (apb_wdata),
    .apb_ready_o  (ram_ready),
    .apb_rdata_o  (ram_rdata)
  );

  apb_regs #(
    .ADDR_W (ADDR_W),
    .DATA_W (DATA_W)
  ) apb_regs_inst (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .apb_sel_i    (regs_sel),
    .apb_enable_i (apb_enable),
    .apb_addr_i   (apb_addr),
    .apb_write_i  (apb_write),
    .apb_wstrb_i  (apb_wstrb),
    .apb_wdata_i  (apb_wdata),
    .apb_ready_o  (regs_ready),
    .apb_rdata_o  (regs_rdata)
  );

endmodule

//--- tb/clk_gen.sv
`timescale 1ns/1ps

module clk_gen #(
  parameter int PERIOD_NS  = 100,
  parameter int RST_CYCLES = 4
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS/2) clk_o = ~clk_o;
  end

  // Reset held over the first RST_CYCLES rising edges
  initial begin
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_o);
    #1 rst_o = 1'b0;
  end

endmodule

//--- tb/apb_subsys_tb.sv
`timescale 1ns/1ps

module apb_subsys_tb;

  localparam int RAM_ADDR_W  = 8;
  localparam int RAM_WAIT    = 2;
  localparam int TIMEOUT_CYC = 40;  // Limit for every wait loop
  localparam int DRIVE_DLY   = 1;   // ns after the rising edge

  typedef struct packed {
    logic [31:0] addr;
    logic        is_read;
    logic [31:0] exp_data;
    logic [31:0] known;        // Bytes the model can vouch for
    logic [31:0] act_data;
    int          latency;
    int          exp_latency;
    logic        hs_ok;        // ready and rvalid kept their shape
  } resp_t;

  logic        clk, rst;
  logic        iob_avalid;
  logic [31:0] iob_addr, iob_wdata;
  logic [3:0]  iob_wstrb;
  logic        iob_ready, iob_rvalid;
  logic [31:0] iob_rdata;

  // Reference images
  logic [31:0] ram_img   [2**RAM_ADDR_W];
  logic [31:0] ram_known [2**RAM_ADDR_W];
  logic [31:0] scratch_img [2];
  logic [31:0] wcount_img;

  resp_t resp_q [$];
  int    cycle_cnt   = 0;
  int    cmp_checks  = 0;
  int    cmp_errors  = 0;
  int    main_checks = 0;
  int    main_errors = 0;
  int    tests       = 0;
  int    err_mark    = 0;
  logic  timed_out   = 1'b0;

  clk_gen #(.PERIOD_NS(100), .RST_CYCLES(4)) clk_gen_inst (.clk_o(clk), .rst_o(rst));

  apb_subsys_top #(
    .RAM_ADDR_W (RAM_ADDR_W),
    .RAM_WAIT   (RAM_WAIT)
  ) apb_subsys_top_inst (
    .clk_i        (clk),
    .rst_i        (rst),
    .iob_avalid_i (iob_avalid),
    .iob_addr_i   (iob_addr),
    .iob_wdata_i  (iob_wdata),
    .iob_wstrb_i  (iob_wstrb),
    .iob_ready_o  (iob_ready),
    .iob_rvalid_o (iob_rvalid),
    .iob_rdata_o  (iob_rdata)
  );

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  function automatic logic [31:0] strobe_mask(input logic [3:0] strb);
    return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
  endfunction

  // Expected read data after applying the access to the images
  function automatic logic [31:0] model_access(input logic [31:0] addr, input logic [31:0] wdata,
                                               input logic [3:0] wstrb, output logic [31:0] known);
    logic [31:0]           m;
    logic [RAM_ADDR_W-1:0] w;
    logic [1:0]            r;
    m     = strobe_mask(wstrb);
    w     = addr[RAM_ADDR_W+1:2];
    r     = addr[3:2];
    known = '1;
    if (!addr[apb_pkg::SLAVE_SEL_BIT]) begin
      if (wstrb != 4'h0) begin
        ram_img[w]   = (ram_img[w] & ~m) | (wdata & m);
        ram_known[w] = ram_known[w] | m;
      end
      known = ram_known[w];  // RAM starts out unknown
      return ram_img[w];
    end
    if (wstrb != 4'h0) begin
      wcount_img = wcount_img + 32'd1;  // Any index counts
      if (r == apb_pkg::REG_SCRATCH0 || r == apb_pkg::REG_SCRATCH1)
        scratch_img[r[0]] = (scratch_img[r[0]] & ~m) | (wdata & m);
    end
    if (r == apb_pkg::REG_ID) return apb_pkg::REG_ID_VALUE;
    if (r == apb_pkg::REG_WCOUNT) return wcount_img;
    return scratch_img[r[0]];
  endfunction

  function automatic logic [31:0] ram_addr();
    return {20'h0, 1'b0, 9'($urandom()), 2'b00};
  endfunction

  function automatic logic [31:0] reg_addr(input logic [1:0] idx);
    return {20'h0, 1'b1, 7'($urandom()), idx, 2'b00};  // Upper bits alias
  endfunction

  // One IOb transfer, entered and left just after a rising edge
  task automatic issue(input logic [31:0] addr, input logic [31:0] wdata, input logic [3:0] wstrb);
    resp_t       rec;
    logic [31:0] known;
    int          acc_cyc;
    int          waited;
    if (!timed_out) begin
      rec.addr        = addr;
      rec.is_read     = (wstrb == 4'h0);
      rec.exp_data    = model_access(addr, wdata, wstrb, known);
      rec.known       = known;
      rec.exp_latency = addr[apb_pkg::SLAVE_SEL_BIT] ? 3 : 3 + RAM_WAIT;
      rec.hs_ok       = 1'b1;
      iob_avalid = 1'b1;
      iob_addr   = addr;
      iob_wdata  = wdata;
      iob_wstrb  = wstrb;
      waited     = 0;
      @(negedge clk);
      while (!iob_ready && waited < TIMEOUT_CYC) begin
        waited++;
        @(negedge clk);
      end
      if (iob_rvalid) rec.hs_ok = 1'b0;  // Last pulse lasted too long
      if (!iob_ready) begin
        $display("Timeout at %0t ns: the bridge never accepted a request to %h", $time, addr);
        timed_out = 1'b1;
      end else begin
        acc_cyc = cycle_cnt;
        @(posedge clk);
        #DRIVE_DLY;
        iob_avalid = 1'b0;
        waited     = 0;
        @(negedge clk);
        while (!iob_rvalid && waited < TIMEOUT_CYC) begin
          if (iob_ready) rec.hs_ok = 1'b0;
          waited++;
          @(negedge clk);
        end
        if (!iob_rvalid) begin
          $display("Timeout at %0t ns: no response came for address %h", $time, addr);
          timed_out = 1'b1;
        end else begin
          if (!iob_ready) rec.hs_ok = 1'b0;
          rec.act_data = iob_rdata;
          rec.latency  = cycle_cnt - acc_cyc;
          resp_q.push_back(rec);
          @(posedge clk);
          #DRIVE_DLY;
        end
      end
      iob_avalid = 1'b0;
    end
  endtask

  // Compare each finished transfer with the model
  always @(posedge clk) begin
    resp_t r;
    while (resp_q.size() > 0) begin
      r = resp_q.pop_front();
      cmp_checks++;
      if (r.is_read && ((r.act_data & r.known) !== (r.exp_data & r.known))) begin
        cmp_errors++;
        $display("error at %0t ns: read of %h expected %h got %h", $time, r.addr,
                 r.exp_data & r.known, r.act_data & r.known);
      end
      if (r.latency != r.exp_latency) begin
        cmp_errors++;
        $display("error at %0t ns: access to %h expected %0d cycles got %0d", $time, r.addr,
                 r.exp_latency, r.latency);
      end
      if (!r.hs_ok) begin
        cmp_errors++;
        $display("error at %0t ns: access to %h expected ready low until a one-cycle rvalid",
                 $time, r.addr);
      end
    end
  end

  task automatic check_idle(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      main_checks++;
      if (!iob_ready || iob_rvalid) begin
        main_errors++;
        $display("error at %0t ns: idle port expected ready 1 rvalid 0 got %b %b", $time,
                 iob_ready, iob_rvalid);
      end
    end
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic report_test(input string name);
    int total;
    total = cmp_errors + main_errors;
    tests++;
    if (timed_out) $display("test %0d %s: stopped by a timeout", tests, name);
    else if (total == err_mark) $display("test %0d %s: ok", tests, name);
    else $display("test %0d %s: %0d errors", tests, name, total - err_mark);
    err_mark = total;
  endtask

  initial begin
    int          waited;
    logic [31:0] addrs [16];
    logic [31:0] addr;
    logic [3:0]  strb;
    void'($urandom(73));
    iob_avalid = 1'b0;
    iob_addr   = '0;
    iob_wdata  = '0;
    iob_wstrb  = '0;
    foreach (ram_img[i]) begin
      ram_img[i]   = '0;
      ram_known[i] = '0;
    end
    scratch_img[0] = '0;
    scratch_img[1] = '0;
    wcount_img     = '0;

    waited = 0;
    @(negedge clk);
    while (rst && waited < TIMEOUT_CYC) begin
      waited++;
      @(negedge clk);
    end
    if (rst) begin
      $display("Timeout at %0t ns: reset was never released", $time);
      timed_out = 1'b1;
    end
    @(posedge clk);
    #DRIVE_DLY;

    check_idle(6);
    report_test("reset state");

    // Full words first, then partial strobes over the same words
    for (int i = 0; i < 16; i++) begin
      addrs[i] = ram_addr();
      issue(addrs[i], $urandom(), 4'hF);
    end
    for (int i = 0; i < 16; i++) issue(addrs[i], 32'h0, 4'h0);
    for (int i = 0; i < 16; i++) issue(addrs[i], $urandom(), 4'($urandom_range(14, 1)));
    for (int i = 0; i < 16; i++) issue(addrs[i], 32'h0, 4'h0);
    report_test("ram writes and reads");

    issue(reg_addr(apb_pkg::REG_SCRATCH0), 32'h1122_3344, 4'hF);
    issue(reg_addr(apb_pkg::REG_SCRATCH0), 32'hAABB_CCDD, 4'b0101);
    issue(reg_addr(apb_pkg::REG_SCRATCH0), 32'h0, 4'h0);
    issue(reg_addr(apb_pkg::REG_SCRATCH1), $urandom(), 4'b1000);
    issue(reg_addr(apb_pkg::REG_SCRATCH1), $urandom(), 4'b0011);
    issue(reg_addr(apb_pkg::REG_SCRATCH1), 32'h0, 4'h0);
    issue(reg_addr(apb_pkg::REG_ID), 32'h0, 4'h0);
    issue(reg_addr(apb_pkg::REG_ID), 32'hFFFF_FFFF, 4'hF);  // Must be ignored
    issue(reg_addr(apb_pkg::REG_ID), 32'h0, 4'h0);
    report_test("register block");

    issue(reg_addr(apb_pkg::REG_WCOUNT), 32'h0, 4'h0);
    for (int i = 0; i < 5; i++) issue(reg_addr(2'($urandom())), $urandom(), 4'hF);
    for (int i = 0; i < 3; i++) issue(ram_addr(), $urandom(), 4'hF);  // Not counted
    issue(reg_addr(apb_pkg::REG_WCOUNT), 32'h0, 4'h0);
    report_test("write counter");

    for (int i = 0; i < 4; i++) begin
      issue(reg_addr(2'(i)), 32'h0, 4'h0);
      issue(ram_addr(), $urandom(), 4'hF);
    end
    report_test("latency");

    // Back to back across both slaves
    for (int i = 0; i < 200; i++) begin
      if ($urandom_range(1, 0) == 0) strb = 4'h0;
      else strb = 4'($urandom_range(15, 1));
      if ($urandom_range(1, 0) == 0) addr = ram_addr();
      else addr = reg_addr(2'($urandom()));
      issue(addr, $urandom(), strb);
    end
    check_idle(3);
    report_test("mixed random sequence");

    $display("tests %0d, checks %0d, errors %0d", tests, cmp_checks + main_checks,
             cmp_errors + main_errors);
    if (cmp_errors + main_errors == 0 && !timed_out) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- files.f
design/apb_pkg.sv
design/iob2apb.sv
design/apb_decoder.sv
design/apb_ram.sv
design/apb_regs.sv
design/apb_subsys_top.sv
tb/clk_gen.sv
tb/apb_subsys_tb.sv

//--- run.sh
#!/bin/sh
# Compile and run the APB subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/1ps -f files.f \
    --top-module apb_subsys_tb -Mdir obj_dir; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vapb_subsys_tb)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qF '** PASS **'; then
  exit 0
fi
echo "Simulation did not pass"
exit 1
